// File: hdl/gat_sched_defines.svh
// Project-wide sizes for the GAT layer parameter scheduler
`ifndef GAT_SCHED_DEFINES_SVH
`define GAT_SCHED_DEFINES_SVH

// ==============================
// Word and feature sizes
// ==============================

// Width of one parameter memory word
`define GAT_DATA_W      8

// Layer-1 weight matrix is FEAT_IN rows by FEAT_OUT columns
`define GAT_FEAT_IN     8
`define GAT_FEAT_OUT    4

// Layer-2 output features
`define GAT_FEAT_FINAL  3

// ==============================
// Region sizes in words
// ==============================
`define GAT_W1_WORDS    (`GAT_FEAT_IN * `GAT_FEAT_OUT)
`define GAT_A1_WORDS    (2 * `GAT_FEAT_OUT)
`define GAT_W2_WORDS    (`GAT_FEAT_OUT * `GAT_FEAT_FINAL)

// Words the scheduler walks in total
`define GAT_TOTAL_WORDS (`GAT_W1_WORDS + `GAT_A1_WORDS + `GAT_W2_WORDS)

`endif

// File: hdl/gat_sched_pkg.sv
// Types shared by the GAT parameter scheduler blocks
`include "gat_sched_defines.svh"

package gat_sched_pkg;

  // ==============================
  // Parameter memory regions
  // ==============================

  // Order matches the layout of the parameter memory
  typedef enum logic [1:0] {
    REG_W1,
    REG_A1,
    REG_W2,
    REG_DONE
  } param_region_e;

  // ==============================
  // Derived widths
  // ==============================

  // Address and word index, wide enough to hold the saturated count
  typedef logic [$clog2(`GAT_TOTAL_WORDS + 1)-1:0] word_idx_t;

  typedef logic [`GAT_DATA_W-1:0] data_t;

  // Layer-1 weight position
  typedef logic [$clog2(`GAT_FEAT_IN)-1:0]  w1_row_t;
  typedef logic [$clog2(`GAT_FEAT_OUT)-1:0] w1_col_t;

endpackage

// File: hdl/param_fetch.sv
// Walks the parameter memory and tags each returned word with its index and region
`timescale 1ns/1ps
`include "gat_sched_defines.svh"

module param_fetch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          sched_vld_i,
  output gat_sched_pkg::word_idx_t      wgt_bram_addr_o,
  input  gat_sched_pkg::data_t          wgt_bram_dout_i,
  output logic                          word_vld_o,
  output gat_sched_pkg::word_idx_t      word_idx_o,
  output gat_sched_pkg::data_t          word_data_o,
  output gat_sched_pkg::param_region_e  word_region_o,
  output logic                          w1_wr_o,
  output gat_sched_pkg::w1_row_t        w1_row_o,
  output gat_sched_pkg::w1_col_t        w1_col_o
);

  import gat_sched_pkg::*;

  word_idx_t     addr_q;
  logic          addr_issue;
  logic          vld_q;
  word_idx_t     idx_q;
  param_region_e region;
  logic          w1_wr;
  w1_row_t       row_q;
  w1_col_t       col_q;

  // ==============================
  // Address counter
  // ==============================

  // Stops at TOTAL_WORDS, pauses while sched_vld_i is low
  assign addr_issue = sched_vld_i && (addr_q < word_idx_t'(`GAT_TOTAL_WORDS));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (addr_issue) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // Memory answers one cycle later, so strobe and index follow by one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
      idx_q <= '0;
    end else begin
      vld_q <= addr_issue;
      if (addr_issue) begin
        idx_q <= addr_q;
      end
    end
  end

  // ==============================
  // Region decode
  // ==============================
  always_comb begin
    if (idx_q < word_idx_t'(`GAT_W1_WORDS)) begin
      region = REG_W1;
    end else if (idx_q < word_idx_t'(`GAT_W1_WORDS + `GAT_A1_WORDS)) begin
      region = REG_A1;
    end else if (idx_q < word_idx_t'(`GAT_TOTAL_WORDS)) begin
      region = REG_W2;
    end else begin
      region = REG_DONE;
    end
  end

  assign w1_wr = vld_q && (region == REG_W1);

  // Row-major walk of layer-1 weights, column steps first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_q <= '0;
      col_q <= '0;
    end else if (w1_wr) begin
      if (col_q == w1_col_t'(`GAT_FEAT_OUT - 1)) begin
        col_q <= '0;
        row_q <= (row_q == w1_row_t'(`GAT_FEAT_IN - 1)) ? '0 : row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  assign wgt_bram_addr_o = addr_q;
  assign word_vld_o      = vld_q;
  assign word_idx_o      = idx_q;
  assign word_data_o     = wgt_bram_dout_i;
  assign word_region_o   = region;
  assign w1_wr_o         = w1_wr;
  assign w1_row_o        = row_q;
  assign w1_col_o        = col_q;

endmodule

// File: hdl/conv1_weight_banks.sv
// Layer-1 weight storage with one memory bank and read port per column
`timescale 1ns/1ps
`include "gat_sched_defines.svh"

module conv1_weight_banks (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          w1_wr_i,
  input  gat_sched_pkg::w1_row_t                        w1_row_i,
  input  gat_sched_pkg::w1_col_t                        w1_col_i,
  input  gat_sched_pkg::data_t                          word_data_i,
  input  gat_sched_pkg::w1_row_t [`GAT_FEAT_OUT-1:0]    mult_wgt_addr_i,
  output gat_sched_pkg::data_t   [`GAT_FEAT_OUT-1:0]    mult_wgt_dout_o
);

  import gat_sched_pkg::*;

  // One-hot write enable, one bit per column bank
  logic [`GAT_FEAT_OUT-1:0] bank_we;

  genvar c;

  // ==============================
  // Column banks
  // ==============================
  generate
    for (c = 0; c < `GAT_FEAT_OUT; c++) begin : g_bank
      data_t mem [`GAT_FEAT_IN];
      data_t rd_q;

      // Column select
      assign bank_we[c] = w1_wr_i && (w1_col_i == w1_col_t'(c));

      // Write port, row gives the address
      always_ff @(posedge clk) begin
        if (bank_we[c]) begin
          mem[w1_row_i] <= word_data_i;
        end
      end

      // Registered read port for the multiplier side
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          rd_q <= '0;
        end else begin
          rd_q <= mem[mult_wgt_addr_i[c]];
        end
      end

      assign mult_wgt_dout_o[c] = rd_q;
    end
  endgenerate

endmodule

// File: hdl/param_capture.sv
// Captures layer-1 attention and layer-2 weights and flags when loading is done
`timescale 1ns/1ps
`include "gat_sched_defines.svh"

module param_capture (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   word_vld_i,
  input  gat_sched_pkg::word_idx_t               word_idx_i,
  input  gat_sched_pkg::param_region_e           word_region_i,
  input  gat_sched_pkg::data_t                   word_data_i,
  output gat_sched_pkg::data_t [`GAT_A1_WORDS-1:0] a_conv1_o,
  // Outer index is the layer-2 column, inner index the row
  output gat_sched_pkg::data_t [`GAT_FEAT_FINAL-1:0][`GAT_FEAT_OUT-1:0] wgt_conv2_o,
  output logic                                   sched_rdy_o
);

  import gat_sched_pkg::*;

  localparam int A_IDX_W  = $clog2(`GAT_A1_WORDS);
  localparam int W2_ROW_W = $clog2(`GAT_FEAT_OUT);
  localparam int W2_COL_W = $clog2(`GAT_FEAT_FINAL);

  data_t [`GAT_A1_WORDS-1:0]                     a_q;
  data_t [`GAT_FEAT_FINAL-1:0][`GAT_FEAT_OUT-1:0] w2_q;

  logic [A_IDX_W-1:0]  a_idx;
  word_idx_t           w2_off;
  logic [W2_ROW_W-1:0] w2_row;
  logic [W2_COL_W-1:0] w2_col;
  logic                last_word;
  logic                done_q;
  logic                rdy_q;

  // ==============================
  // Index decode
  // ==============================
  assign a_idx  = A_IDX_W'(word_idx_i - `GAT_W1_WORDS);
  assign w2_off = word_idx_i - word_idx_t'(`GAT_W1_WORDS + `GAT_A1_WORDS);
  assign w2_row = W2_ROW_W'(w2_off / `GAT_FEAT_FINAL);
  assign w2_col = W2_COL_W'(w2_off % `GAT_FEAT_FINAL);

  assign last_word = word_vld_i && (word_idx_i == word_idx_t'(`GAT_TOTAL_WORDS - 1));

  // ==============================
  // Capture registers
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q  <= '0;
      w2_q <= '0;
    end else if (word_vld_i) begin
      if (word_region_i == REG_A1) begin
        a_q[a_idx] <= word_data_i;
      end
      if (word_region_i == REG_W2) begin
        w2_q[w2_col][w2_row] <= word_data_i;
      end
    end
  end

  // Done flag is sticky until reset, ready trails it by a cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
      rdy_q  <= 1'b0;
    end else begin
      if (last_word) begin
        done_q <= 1'b1;
      end
      rdy_q <= done_q;
    end
  end

  assign a_conv1_o   = a_q;
  assign wgt_conv2_o = w2_q;
  assign sched_rdy_o = rdy_q;

endmodule

// File: hdl/gat_weight_scheduler.sv
// Top of the GAT layer parameter scheduler, joins fetch, layer-1 banks and capture
`timescale 1ns/1ps
`include "gat_sched_defines.svh"

module gat_weight_scheduler (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        sched_vld_i,
  output logic                                        sched_rdy_o,
  output gat_sched_pkg::word_idx_t                    wgt_bram_addr_o,
  input  gat_sched_pkg::data_t                        wgt_bram_dout_i,
  input  gat_sched_pkg::w1_row_t [`GAT_FEAT_OUT-1:0]  mult_wgt_addr_i,
  output gat_sched_pkg::data_t   [`GAT_FEAT_OUT-1:0]  mult_wgt_dout_o,
  output gat_sched_pkg::data_t   [`GAT_A1_WORDS-1:0]  a_conv1_o,
  output gat_sched_pkg::data_t [`GAT_FEAT_FINAL-1:0][`GAT_FEAT_OUT-1:0] wgt_conv2_o
);

  import gat_sched_pkg::*;

  // Aligned word stream from the fetch stage
  logic          word_vld;
  word_idx_t     word_idx;
  data_t         word_data;
  param_region_e word_region;

  // Layer-1 write position
  logic          w1_wr;
  w1_row_t       w1_row;
  w1_col_t       w1_col;

  // ==============================
  // Fetch, banks, capture
  // ==============================
  param_fetch u_param_fetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .sched_vld_i     (sched_vld_i),
    .wgt_bram_addr_o (wgt_bram_addr_o),
    .wgt_bram_dout_i (wgt_bram_dout_i),
    .word_vld_o      (word_vld),
    .word_idx_o      (word_idx),
    .word_data_o     (word_data),
    .word_region_o   (word_region),
    .w1_wr_o         (w1_wr),
    .w1_row_o        (w1_row),
    .w1_col_o        (w1_col)
  );

  conv1_weight_banks u_conv1_weight_banks (
    .clk             (clk),
    .rst_n           (rst_n),
    .w1_wr_i         (w1_wr),
    .w1_row_i        (w1_row),
    .w1_col_i        (w1_col),
    .word_data_i     (word_data),
    .mult_wgt_addr_i (mult_wgt_addr_i),
    .mult_wgt_dout_o (mult_wgt_dout_o)
  );

  param_capture u_param_capture (
    .clk             (clk),
    .rst_n           (rst_n),
    .word_vld_i      (word_vld),
    .word_idx_i      (word_idx),
    .word_region_i   (word_region),
    .word_data_i     (word_data),
    .a_conv1_o       (a_conv1_o),
    .wgt_conv2_o     (wgt_conv2_o),
    .sched_rdy_o     (sched_rdy_o)
  );

endmodule

// File: verification/gat_weight_scheduler_sva.sv
// Concurrent checks on the parameter fetch address counter and word strobe
`timescale 1ns/1ps
`include "gat_sched_defines.svh"

module gat_weight_scheduler_sva (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      sched_vld_i,
  input gat_sched_pkg::word_idx_t  addr_i,
  input logic                      word_vld_i,
  input gat_sched_pkg::word_idx_t  word_idx_i
);

  import gat_sched_pkg::*;

  // Address accepted by the memory this cycle
  logic issue;
  int   fail_cnt = 0;

  assign issue = sched_vld_i && (addr_i < word_idx_t'(`GAT_TOTAL_WORDS));

  // ==============================
  // Address behavior
  // ==============================
  addr_no_decrement: assert property (@(posedge clk) disable iff (!rst_n)
    addr_i >= $past(addr_i))
    else begin
      fail_cnt++;
      $error("Parameter address decremented");
    end

  addr_hold_on_pause: assert property (@(posedge clk) disable iff (!rst_n)
    !sched_vld_i |=> $stable(addr_i))
    else begin
      fail_cnt++;
      $error("Parameter address moved while sched_vld_i was low");
    end

  // ==============================
  // Word strobe alignment
  // ==============================
  word_follows_issue: assert property (@(posedge clk) disable iff (!rst_n)
    issue |=> (word_vld_i && (word_idx_i == $past(addr_i))))
    else begin
      fail_cnt++;
      $error("Word strobe or index did not follow the issued address");
    end

  no_word_without_issue: assert property (@(posedge clk) disable iff (!rst_n)
    !issue |=> !word_vld_i)
    else begin
      fail_cnt++;
      $error("Word strobe without an issued address");
    end

endmodule

bind param_fetch gat_weight_scheduler_sva u_fetch_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .sched_vld_i (sched_vld_i),
  .addr_i      (wgt_bram_addr_o),
  .word_vld_i  (word_vld_o),
  .word_idx_i  (word_idx_o)
);

// File: verification/gat_weight_scheduler_tb.sv
// Testbench for the GAT parameter scheduler with a random parameter memory model
`timescale 1ns/1ps
`include "gat_sched_defines.svh"

module gat_weight_scheduler_tb;

  import gat_sched_pkg::*;

  localparam int CLK_HALF   = 50;
  localparam int RST_CYCLES = 5;
  localparam int NUM_PHASES = 9;
  localparam int RAND_SEED  = 32'hc4be_e6cf;

  // ==============================
  // Stimulus table
  // ==============================

  // Each phase holds sched_vld_i at a level for a number of cycles
  localparam int PHASE_VLD [NUM_PHASES] = '{1, 0, 1, 0, 1, 0, 1, 0, 1};
  localparam int PHASE_LEN [NUM_PHASES] = '{10, 4, 7, 3, 1, 1, 1, 5, 40};

  logic                                        clk;
  logic                                        rst_n;
  logic                                        sched_vld_i;
  logic                                        sched_rdy_o;
  word_idx_t                                   wgt_bram_addr_o;
  data_t                                       wgt_bram_dout_i;
  w1_row_t [`GAT_FEAT_OUT-1:0]                 mult_wgt_addr_i;
  data_t   [`GAT_FEAT_OUT-1:0]                 mult_wgt_dout_o;
  data_t   [`GAT_A1_WORDS-1:0]                 a_conv1_o;
  data_t   [`GAT_FEAT_FINAL-1:0][`GAT_FEAT_OUT-1:0] wgt_conv2_o;

  // Memory model contents
  data_t     param_mem [`GAT_TOTAL_WORDS];
  word_idx_t mem_addr_q;
  logic      last_addr_seen = 1'b0;
  logic      rdy_seen = 1'b0;
  int        cycle_cnt = 0;
  int        timeout_limit = 0;

  gat_weight_scheduler UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .sched_vld_i     (sched_vld_i),
    .sched_rdy_o     (sched_rdy_o),
    .wgt_bram_addr_o (wgt_bram_addr_o),
    .wgt_bram_dout_i (wgt_bram_dout_i),
    .mult_wgt_addr_i (mult_wgt_addr_i),
    .mult_wgt_dout_o (mult_wgt_dout_o),
    .a_conv1_o       (a_conv1_o),
    .wgt_conv2_o     (wgt_conv2_o)
  );

  always #(CLK_HALF) clk = ~clk;

  // ==============================
  // Helpers
  // ==============================
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped on first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Error %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  function automatic int table_cycles();
    int total;
    total = 0;
    for (int p = 0; p < NUM_PHASES; p++) begin
      total += PHASE_LEN[p];
    end
    return total;
  endfunction

  // Parameter memory, data one cycle after the address
  always @(posedge clk) begin
    mem_addr_q = wgt_bram_addr_o;
    if (sched_vld_i && (mem_addr_q == word_idx_t'(`GAT_TOTAL_WORDS - 1))) begin
      last_addr_seen = 1'b1;
    end
    #1;
    if (mem_addr_q < word_idx_t'(`GAT_TOTAL_WORDS)) begin
      wgt_bram_dout_i = param_mem[mem_addr_q];
    end else begin
      wgt_bram_dout_i = '0;
    end
  end

  // Run-wide monitor and watchdog
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > timeout_limit) begin
      abort_run($sformatf("Timeout, sched_rdy_o not done within %0d cycles", timeout_limit));
    end
    if (rst_n) begin
      if (wgt_bram_addr_o > word_idx_t'(`GAT_TOTAL_WORDS)) begin
        abort_run("Parameter address ran past the end of the memory");
      end
      if (sched_rdy_o && !last_addr_seen) begin
        abort_run("sched_rdy_o rose before the final address was requested");
      end
      if (rdy_seen && !sched_rdy_o) begin
        abort_run("sched_rdy_o dropped after it had risen");
      end
      if (sched_rdy_o) begin
        rdy_seen = 1'b1;
      end
    end
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    int        p;
    int        n;
    int        row;
    word_idx_t hold_addr;

    clk             = 1'b0;
    rst_n           = 1'b0;
    sched_vld_i     = 1'b0;
    wgt_bram_dout_i = '0;
    mult_wgt_addr_i = '0;

    void'($urandom(RAND_SEED));
    for (int a = 0; a < `GAT_TOTAL_WORDS; a++) begin
      param_mem[a] = data_t'($urandom);
    end
    timeout_limit = table_cycles() + `GAT_TOTAL_WORDS + 20;

    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset values
    check_value("reset_rdy", 0, sched_rdy_o);
    check_value("reset_addr", 0, wgt_bram_addr_o);
    for (int j = 0; j < `GAT_A1_WORDS; j++) begin
      check_value($sformatf("reset_a_conv1[%0d]", j), 0, a_conv1_o[j]);
    end
    for (int i = 0; i < `GAT_FEAT_FINAL; i++) begin
      for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
        check_value($sformatf("reset_wgt_conv2[%0d][%0d]", k, i), 0, wgt_conv2_o[i][k]);
      end
    end

    // Apply the phases, address must freeze while paused
    for (p = 0; p < NUM_PHASES; p++) begin
      sched_vld_i = PHASE_VLD[p][0];
      hold_addr   = wgt_bram_addr_o;
      for (n = 0; n < PHASE_LEN[p]; n++) begin
        @(posedge clk);
        #1;
        if (PHASE_VLD[p] == 0) begin
          check_value($sformatf("pause_hold_phase%0d", p), hold_addr, wgt_bram_addr_o);
        end
      end
    end

    while (!sched_rdy_o) begin
      @(posedge clk);
      #1;
    end

    // Layer-1 banks, a different row per column each read
    for (int r = 0; r < `GAT_FEAT_IN; r++) begin
      for (int c = 0; c < `GAT_FEAT_OUT; c++) begin
        mult_wgt_addr_i[c] = w1_row_t'((r + c) % `GAT_FEAT_IN);
      end
      @(posedge clk);
      #1;
      for (int c = 0; c < `GAT_FEAT_OUT; c++) begin
        row = (r + c) % `GAT_FEAT_IN;
        check_value($sformatf("w1_row%0d_col%0d", row, c),
                    param_mem[row * `GAT_FEAT_OUT + c], mult_wgt_dout_o[c]);
      end
    end

    // Layer-1 attention vector
    for (int j = 0; j < `GAT_A1_WORDS; j++) begin
      check_value($sformatf("a_conv1[%0d]", j), param_mem[`GAT_W1_WORDS + j], a_conv1_o[j]);
    end

    // Layer-2 weights, row k and column i
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      for (int i = 0; i < `GAT_FEAT_FINAL; i++) begin
        check_value($sformatf("wgt_conv2_row%0d_col%0d", k, i),
                    param_mem[`GAT_W1_WORDS + `GAT_A1_WORDS + k * `GAT_FEAT_FINAL + i],
                    wgt_conv2_o[i][k]);
      end
    end

    // Ready must stay up
    repeat (3) @(posedge clk);
    #1;
    check_value("rdy_sticky", 1, sched_rdy_o);

    if (UUT.u_param_fetch.u_fetch_sva.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run("Concurrent assertions on the fetch stage failed");
    end
  end

endmodule

// File: gat_weight_scheduler.f
+incdir+hdl
hdl/gat_sched_pkg.sv
hdl/param_fetch.sv
hdl/conv1_weight_banks.sv
hdl/param_capture.sv
hdl/gat_weight_scheduler.sv
verification/gat_weight_scheduler_sva.sv
verification/gat_weight_scheduler_tb.sv

// File: Makefile
# Verilator build and run for the GAT parameter scheduler

VERILATOR ?= verilator
TOP       := gat_weight_scheduler_tb
FILELIST  := gat_weight_scheduler.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal
PASS_MSG  := NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
